//--- hw/wr_path_cfg_pkg.sv
// write path widths, address step per beat and derived byte count
package wr_path_cfg_pkg;

  // data side
  localparam int unsigned DATA_W = 64;  // one pu output word == one memory beat

  // bytes moved by one beat
  localparam int unsigned BEAT_BYTES = DATA_W / 8;  // address step between beats

  // address side
  localparam int unsigned ADDR_W = 32;  // byte address into memory

  // macro request fields
  localparam int unsigned SIZE_W  = 10;  // beat count of one macro, up to 1023 beats
  localparam int unsigned PU_ID_W = 2;   // pu index, room for 4 pus

  // a zero-length macro is legal and finishes with no beats

endpackage

//--- hw/wr_path_types_pkg.sv
// packed macro and memory request structs, sequencer state enum
package wr_path_types_pkg;

  import wr_path_cfg_pkg::*;

  // one queued macro write, as handed in by the host
  // the pu id picks which output buffer feeds the beats
  typedef struct packed {
    logic [ADDR_W-1:0]  addr;   // byte address of the first beat
    logic [SIZE_W-1:0]  beats;  // number of beats to write
    logic [PU_ID_W-1:0] pu_id;  // source pu
  } macro_req_t;  // 44 bits

  // one beat as seen by the memory port
  typedef struct packed {
    logic [ADDR_W-1:0] addr;  // already stepped by BEAT_BYTES per beat
    logic [DATA_W-1:0] data;  // word popped from the pu buffer
  } mem_req_t;  // 96 bits

  // sequencer FSM
  // idle waits for a queued macro
  // issue fractures the active macro into beats
  typedef enum logic [0:0] {
    SEQ_IDLE  = 1'b0,
    SEQ_ISSUE = 1'b1
  } seq_state_e;

endpackage

//--- hw/req_fifo.sv
// synchronous show-ahead FIFO with full/empty flags and push/pop assertions
module req_fifo #(
  parameter int WIDTH     = 32,  // payload width
  parameter int LOG_DEPTH = 2    // depth is 2**LOG_DEPTH entries
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,   // write din this cycle
  input  logic [WIDTH-1:0] din,
  input  logic             pop,    // drop the head this cycle
  output logic [WIDTH-1:0] dout,   // head entry while not empty
  output logic             full,
  output logic             empty
);

  localparam int DEPTH = 1 << LOG_DEPTH;

  logic [WIDTH-1:0]   mem [DEPTH];  // payload storage
  logic [LOG_DEPTH-1:0] wr_ptr;       // next slot to write
  logic [LOG_DEPTH-1:0] rd_ptr;       // current head slot
  logic [LOG_DEPTH:0]   count;        // occupancy with one extra bit for full

  // flags come straight off the count
  assign full  = (count == (LOG_DEPTH + 1)'(DEPTH));
  assign empty = (count == '0);

  // show-ahead read so the head is visible right after the writing edge
  assign dout = mem[rd_ptr];

  // payload write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers wrap naturally at DEPTH
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;  // fill
        2'b01:   count <= count - 1'b1;  // drain
        default: count <= count;         // idle or pass-through
      endcase
    end
  end

  // the producer and consumer sit in other modules and must honour the flags
  a_no_push_full : assert property (
    @(posedge clk) disable iff (rst) push |-> !full
  ) else $error("req_fifo push while full");

  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (rst) pop |-> !empty
  ) else $error("req_fifo pop while empty");

endmodule

//--- hw/beat_sequencer.sv
// beat sequencer FSM fracturing macro writes into per-beat memory requests
module beat_sequencer
  import wr_path_cfg_pkg::*;
  import wr_path_types_pkg::*;
#(
  parameter int NUM_PU = 2  // number of pu output buffers
) (
  input  logic                           clk,
  input  logic                           rst,
  // macro queue head
  input  macro_req_t                     macro_head,
  input  logic                           macro_empty,
  output logic                           macro_pop,     // take the head into the FSM
  // pu output buffers
  input  logic [NUM_PU-1:0]              outbuf_empty,
  input  logic [NUM_PU-1:0][DATA_W-1:0]  outbuf_data,   // head word per pu
  output logic [NUM_PU-1:0]              outbuf_pop,
  // request queue
  input  logic                           req_full,
  input  logic                           req_empty,     // only feeds wr_ready
  output logic                           beat_push,
  output mem_req_t                       beat,
  // status
  output logic                           wr_ready,      // nothing queued, active or in flight
  output logic                           wr_done        // one pulse per finished macro
);

  seq_state_e         state;
  seq_state_e         state_nxt;

  // active macro, loaded on macro_pop
  logic [ADDR_W-1:0]  cur_addr;   // address of the next beat
  logic [SIZE_W-1:0]  remaining;  // beats still to issue
  logic [PU_ID_W-1:0] cur_pu;     // source buffer

  logic               sel_empty;  // selected pu buffer flag
  logic [DATA_W-1:0]  sel_data;   // selected pu head word
  logic               issue;      // a beat moves this cycle
  logic [SIZE_W-1:0]  remaining_nxt;
  logic               finish;     // last cycle of the active macro

  // pu mux, an out of range id reads as an empty buffer
  always_comb begin
    sel_empty = 1'b1;
    sel_data  = '0;
    for (int p = 0; p < NUM_PU; p++) begin
      if (cur_pu == PU_ID_W'(p)) begin
        sel_empty = outbuf_empty[p];
        sel_data  = outbuf_data[p];
      end
    end
  end

  // a zero-beat macro never issues and finishes right away
  assign issue = (state == SEQ_ISSUE) && (remaining != '0) && !sel_empty && !req_full;

  assign remaining_nxt = issue ? remaining - SIZE_W'(1) : remaining;
  assign finish        = (state == SEQ_ISSUE) && (remaining_nxt == '0);

  // take a new macro only when idle
  assign macro_pop = (state == SEQ_IDLE) && !macro_empty;

  // beat goes to the request queue with the word it carries
  assign beat_push = issue;
  assign beat.addr = cur_addr;
  assign beat.data = sel_data;

  // pop only the buffer that fed the beat
  always_comb begin
    outbuf_pop = '0;
    for (int p = 0; p < NUM_PU; p++) begin
      outbuf_pop[p] = issue && (cur_pu == PU_ID_W'(p));
    end
  end

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      SEQ_IDLE:  if (macro_pop) state_nxt = SEQ_ISSUE;
      SEQ_ISSUE: if (finish) state_nxt = SEQ_IDLE;
      default:   state_nxt = SEQ_IDLE;
    endcase
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= SEQ_IDLE;
      wr_done <= 1'b0;
    end else begin
      state   <= state_nxt;
      wr_done <= finish;  // registered so the pulse lands one cycle after the last beat
    end
  end

  // active macro fields, only read in SEQ_ISSUE
  always_ff @(posedge clk) begin
    if (macro_pop) begin
      cur_addr  <= macro_head.addr;
      remaining <= macro_head.beats;
      cur_pu    <= macro_head.pu_id;
    end else if (issue) begin
      cur_addr  <= cur_addr + ADDR_W'(BEAT_BYTES);
      remaining <= remaining_nxt;
    end
  end

  // drained once the queue, the FSM and the request queue are all empty
  assign wr_ready = macro_empty && (state == SEQ_IDLE) && req_empty;

  // a pu word is consumed only when it lands in the request queue
  a_pop_has_push : assert property (
    @(posedge clk) disable iff (rst) (outbuf_pop != '0) |-> beat_push
  ) else $error("pu buffer popped without a beat push");

  // host must only name pus that exist
  a_pu_in_range : assert property (
    @(posedge clk) disable iff (rst) macro_pop |-> (int'(macro_head.pu_id) < NUM_PU)
  ) else $error("macro names pu %0d, only %0d pus", macro_head.pu_id, NUM_PU);

  // request queue back-pressure is honoured
  a_push_not_full : assert property (
    @(posedge clk) disable iff (rst) beat_push |-> !req_full
  ) else $error("beat pushed into a full request queue");

endmodule

//--- hw/wr_path_top.sv
// write path top with macro FIFO, beat sequencer, request FIFO and memory port
module wr_path_top
  import wr_path_cfg_pkg::*;
  import wr_path_types_pkg::*;
#(
  parameter int NUM_PU            = 2,  // pu output buffers
  parameter int MACRO_Q_LOG_DEPTH = 2,  // 4 queued macros
  parameter int REQ_Q_LOG_DEPTH   = 3   // 8 beats in flight to memory
) (
  input  logic                          clk,
  input  logic                          rst,
  // host side
  input  logic                          wr_req,        // one-cycle strobe
  input  macro_req_t                    wr_macro,      // valid with wr_req
  output logic                          wr_ready,
  output logic                          wr_done,
  // pu output buffers
  input  logic [NUM_PU-1:0]             outbuf_empty,
  input  logic [NUM_PU-1:0][DATA_W-1:0] outbuf_data,
  output logic [NUM_PU-1:0]             outbuf_pop,
  // memory port
  output logic                          mem_valid,
  output mem_req_t                      mem_req,       // held while waiting for grant
  input  logic                          mem_grant
);

  // per-instance queue widths
  localparam int MACRO_W = $bits(macro_req_t);
  localparam int REQ_W   = $bits(mem_req_t);

  // macro queue
  logic       macro_push;
  logic       macro_pop;
  logic       macro_full;
  logic       macro_empty;
  macro_req_t macro_head;

  // request queue
  logic       beat_push;
  mem_req_t   beat;
  logic       req_pop;
  logic       req_full;
  logic       req_empty;

  // a request arriving on a full queue is dropped
  assign macro_push = wr_req && !macro_full;

  req_fifo #(
    .WIDTH     (MACRO_W),
    .LOG_DEPTH (MACRO_Q_LOG_DEPTH)
  ) macro_q (
    .clk   (clk),
    .rst   (rst),
    .push  (macro_push),
    .din   (wr_macro),
    .pop   (macro_pop),
    .dout  (macro_head),
    .full  (macro_full),
    .empty (macro_empty)
  );

  // fractures the head macro into beats
  beat_sequencer #(
    .NUM_PU (NUM_PU)
  ) seq0 (
    .clk          (clk),
    .rst          (rst),
    .macro_head   (macro_head),
    .macro_empty  (macro_empty),
    .macro_pop    (macro_pop),
    .outbuf_empty (outbuf_empty),
    .outbuf_data  (outbuf_data),
    .outbuf_pop   (outbuf_pop),
    .req_full     (req_full),
    .req_empty    (req_empty),
    .beat_push    (beat_push),
    .beat         (beat),
    .wr_ready     (wr_ready),
    .wr_done      (wr_done)
  );

  req_fifo #(
    .WIDTH     (REQ_W),
    .LOG_DEPTH (REQ_Q_LOG_DEPTH)
  ) req_q (
    .clk   (clk),
    .rst   (rst),
    .push  (beat_push),
    .din   (beat),
    .pop   (req_pop),
    .dout  (mem_req),     // head stays put until granted
    .full  (req_full),
    .empty (req_empty)
  );

  // memory handshake, a beat leaves on valid and grant together
  assign mem_valid = !req_empty;
  assign req_pop   = mem_valid && mem_grant;

endmodule

//--- verif/wr_path_tb.sv
// write path testbench with pu buffer models, grant stimulus, reference model and checker
module wr_path_tb
  import wr_path_cfg_pkg::*;
  import wr_path_types_pkg::*;
;

  localparam int NUM_PU         = 2;
  localparam int PLANNED_BEATS  = 55;  // 12 + 16 + 16 + 6 + 5 + 0 over all tests
  localparam int TIMEOUT_CYCLES = 20 * PLANNED_BEATS + 200;

  typedef logic [DATA_W-1:0] word_list_t [$];
  typedef mem_req_t beat_list_t [$];

  // dut inputs start at known values
  logic                          clk          = 1'b0;
  logic                          rst          = 1'b1;
  logic                          wr_req       = 1'b0;
  macro_req_t                    wr_macro     = '0;
  logic [NUM_PU-1:0]             outbuf_empty = '1;
  logic [NUM_PU-1:0][DATA_W-1:0] outbuf_data  = '0;
  logic                          mem_grant    = 1'b0;

  // dut outputs
  logic                          wr_ready;
  logic                          wr_done;
  logic [NUM_PU-1:0]             outbuf_pop;
  logic                          mem_valid;
  mem_req_t                      mem_req;

  // testbench state
  logic [DATA_W-1:0] model_q [NUM_PU][$];  // words visible to the dut with the head first
  logic [DATA_W-1:0] feed_q [NUM_PU][$];   // words waiting to enter a pu buffer
  mem_req_t          exp_q [$];            // expected beats in memory order
  logic              grant_random = 1'b0;  // random grant when set and constant grant otherwise
  logic              starve       = 1'b0;  // words trickle into the buffers when set
  int                done_count   = 0;
  int                pop_count    = 0;
  int                grant_count  = 0;
  int                cycle_count  = 0;
  logic              prev_stall   = 1'b0;  // valid without grant last cycle
  mem_req_t          prev_req     = '0;

  always #5 clk = ~clk;  // period 10

  wr_path_top #(
    .NUM_PU            (NUM_PU),
    .MACRO_Q_LOG_DEPTH (2),
    .REQ_Q_LOG_DEPTH   (3)
  ) dut0 (
    .clk          (clk),
    .rst          (rst),
    .wr_req       (wr_req),
    .wr_macro     (wr_macro),
    .wr_ready     (wr_ready),
    .wr_done      (wr_done),
    .outbuf_empty (outbuf_empty),
    .outbuf_data  (outbuf_data),
    .outbuf_pop   (outbuf_pop),
    .mem_valid    (mem_valid),
    .mem_req      (mem_req),
    .mem_grant    (mem_grant)
  );

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [ADDR_W+DATA_W-1:0] exp_val,
                             input logic [ADDR_W+DATA_W-1:0] act_val);
    if (exp_val !== act_val) begin
      $display("ERROR time %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
      stop_run();
    end
  endtask

  // beat k goes to addr + k * BEAT_BYTES and carries the k-th word of its pu
  function automatic beat_list_t expected_beats(input macro_req_t m, input word_list_t words);
    beat_list_t list;
    mem_req_t   b;
    for (int k = 0; k < int'(m.beats); k++) begin
      b.addr = m.addr + ADDR_W'(k * BEAT_BYTES);
      b.data = words[k];
      list.push_back(b);
    end
    return list;
  endfunction

  // fresh words for the pu and their expected beats before a one-cycle wr_req strobe
  task automatic send_macro(input logic [ADDR_W-1:0] addr, input int beats, input int pu);
    macro_req_t m;
    word_list_t words;
    beat_list_t exp_list;
    m.addr  = addr;
    m.beats = SIZE_W'(beats);
    m.pu_id = PU_ID_W'(pu);
    for (int k = 0; k < beats; k++) begin
      words.push_back({$urandom, $urandom});
    end
    @(negedge clk);  // away from the edge where the model and checker run
    foreach (words[k]) feed_q[pu].push_back(words[k]);
    exp_list = expected_beats(m, words);
    foreach (exp_list[k]) exp_q.push_back(exp_list[k]);
    @(posedge clk);
    wr_req   <= 1'b1;
    wr_macro <= m;
    @(posedge clk);
    wr_req   <= 1'b0;
  endtask

  // drained means ready again with every done pulse seen
  task automatic wait_drained(input int done_target);
    @(negedge clk);
    while (!(wr_ready && done_count >= done_target)) begin
      @(negedge clk);
    end
    check_value("done_count", done_target, done_count);
    check_value("exp_q.size", 0, exp_q.size());
  endtask

  // pu buffer models where a sampled pop drops the head word
  always @(posedge clk) begin
    for (int p = 0; p < NUM_PU; p++) begin
      if (!rst && outbuf_pop[p] === 1'b1) begin
        if (model_q[p].size() == 0) begin
          $display("pu %0d buffer popped while empty at time %0t", p, $time);
          stop_run();
        end
        void'(model_q[p].pop_front());
        pop_count++;
      end
      if (feed_q[p].size() != 0 && (!starve || ($urandom % 4) == 0)) begin
        model_q[p].push_back(feed_q[p].pop_front());  // random gaps when starving
      end
      outbuf_empty[p] <= (model_q[p].size() == 0);
      outbuf_data[p]  <= (model_q[p].size() != 0) ? model_q[p][0] : '0;
    end
  end

  // memory grant stimulus
  always @(posedge clk) begin
    mem_grant <= grant_random ? 1'(($urandom % 2) != 0) : 1'b1;
  end

  // done pulse counter
  always @(posedge clk) begin
    if (!rst && wr_done === 1'b1) begin
      done_count++;
    end
  end

  // compare every granted beat against the reference list
  always @(posedge clk) begin
    if (!rst) begin
      if (prev_stall) begin  // a stalled request must hold
        check_value("mem_valid", 1, mem_valid);
        check_value("mem_req", prev_req, mem_req);
      end
      if (mem_valid === 1'b1 && mem_grant === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("memory beat granted with none expected at time %0t", $time);
          stop_run();
        end
        check_value("mem_req.addr", exp_q[0].addr, mem_req.addr);
        check_value("mem_req.data", exp_q[0].data, mem_req.data);
        void'(exp_q.pop_front());
        grant_count++;
      end
      prev_stall <= (mem_valid === 1'b1) && !mem_grant;
      prev_req   <= mem_req;
    end
  end

  // run limit from the planned beat count
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d beats still expected",
               cycle_count, exp_q.size());
      stop_run();
    end
  end

  initial begin
    int          pops_before;
    int          grants_before;
    void'($urandom(31));
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // idle outputs after reset
    check_value("mem_valid", 0, mem_valid);
    check_value("outbuf_pop", 0, outbuf_pop);
    check_value("wr_done", 0, wr_done);
    check_value("wr_ready", 1, wr_ready);

    // single macro under constant grant
    send_macro(32'h0000_1000, 12, 0);
    wait_drained(1);

    // random grant exercises the hold rule
    grant_random = 1'b1;
    send_macro(32'h0002_0040, 16, 1);
    wait_drained(2);

    // buffers fill at random gaps
    starve = 1'b1;
    send_macro(32'h0003_0008, 16, 0);
    wait_drained(3);

    // second macro queues behind the first
    send_macro(32'h0004_0000, 6, 1);
    send_macro(32'h0005_0100, 5, 0);
    wait_drained(5);

    // zero-length macro gives a done pulse only
    grant_random = 1'b0;
    starve       = 1'b0;
    pops_before   = pop_count;
    grants_before = grant_count;
    send_macro(32'h0006_0000, 0, 0);
    wait_drained(6);
    check_value("pop_count", pops_before, pop_count);
    check_value("grant_count", grants_before, grant_count);

    repeat (3) @(negedge clk);
    if (exp_q.size() != 0 || grant_count != PLANNED_BEATS || pop_count != PLANNED_BEATS) begin
      $display("run ended with %0d beats granted and %0d pops, %0d planned",
               grant_count, pop_count, PLANNED_BEATS);
      stop_run();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

//--- flist.f
hw/wr_path_cfg_pkg.sv
hw/wr_path_types_pkg.sv
hw/req_fifo.sv
hw/beat_sequencer.sv
hw/wr_path_top.sv
verif/wr_path_tb.sv

//--- Makefile
# Verilator build and run of the write path testbench

TOP := wr_path_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"

# build, run, and fail unless the pass line shows up in the output
test:
	verilator --binary --timing --assert -Wno-fatal -sv \
		--top-module $(TOP) -Mdir obj_dir -f flist.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
